/* source/ir_config.svh */
// Sizes and Wishbone map for the IR board; the diagnostic base must stay aligned to 8 words
`ifndef IR_CONFIG_SVH
`define IR_CONFIG_SVH

// Full 512 word dispatch RAM, no even/odd halving
`define IR_DRAM_SIZE 512
`define IR_DRAM_ADDR_BITS 9

// Width of the adder output seen by the IR board
`define IR_AD_WIDTH 36

// Wishbone classic slave bus widths
`define IR_WB_ADR_WIDTH 10
`define IR_WB_DATA_WIDTH 16

// Words 0x000..0x1FF map the dispatch RAM, then control and diagnostics
`define IR_CTRL_ADR 10'h200
`define IR_DIAG_BASE 10'h208

`endif

/* source/ir_pkg.sv */
// Field types for the IR board model; bit numbering follows KL10 big-endian order (bit 0 is MSB)
package ir_pkg;

  // Instruction field as latched into the IR
  // Bits 0..8 are the opcode and bits 9..12 the AC field
  typedef logic [0:12] instrT;

  // AC field on its own, keeps the IR bit numbers
  typedef logic [9:12] acT;

  // Dispatch A (operand fetch mode) and B (store mode / test select) fields
  typedef logic [0:2] fieldAbT;

  // Upper part of the dispatch J field
  // J bits 5 and 6 are always zero in the microcode so they are not stored
  typedef logic [1:4] jHighT;

  // Lower part of the dispatch J field, replaced by AC on a JRST
  typedef logic [7:10] jLowT;

  // One dispatch RAM word, 15 bits, A lands in the top bits of the packed word
  typedef struct packed {
    fieldAbT a;
    fieldAbT b;
    logic    par;
    jHighT   jHigh;
    jLowT    jLow;
  } dramEntryT;

  // Dispatch RAM address
  typedef logic [0:8] dradrT;

  // Normalize priority code, 0 means AD is all zero
  typedef logic [0:2] normT;

endpackage

/* source/dispatchRam.sv */
// Dual port dispatch RAM with registered reads on both ports; a same-address read returns old data
`timescale 1ns/10ps
`include "ir_config.svh"

module dispatchRam (
  input  logic                                 CON,
  input  ir_pkg::dradrT                        rdAdr,
  input  logic [`IR_DRAM_ADDR_BITS-1:0]        wbAdr,
  input  logic                                 wbWe,
  input  logic [$bits(ir_pkg::dramEntryT)-1:0] wbWdata,
  output logic [$bits(ir_pkg::dramEntryT)-1:0] rdData,
  output logic [$bits(ir_pkg::dramEntryT)-1:0] wbRdata
);

  import ir_pkg::*;

  // All 512 words are kept, each one a packed dispatch entry
  dramEntryT mem [`IR_DRAM_SIZE];

  // Dispatch port
  // The address only moves on loadDram, so reading every cycle is harmless
  // and the word is ready one edge after the address register updates
  always_ff @(posedge CON) begin
    rdData <= mem[rdAdr];
  end

  // Diagnostic port used by the Wishbone slave to load and check the RAM
  // The write lands on the request edge and the read gives the previous word
  always_ff @(posedge CON) begin
    if (wbWe) begin
      mem[wbAdr] <= dramEntryT'(wbWdata);
    end
    wbRdata <= mem[wbAdr];
  end

endmodule

/* source/dispatchAddress.sv */
// Dispatch address former; the 7XX remap is only active while enIoJrst is set
`timescale 1ns/10ps

module dispatchAddress (
  input  logic          CON,
  input  logic          rstN,
  input  ir_pkg::instrT ir,
  input  logic          enIoJrst,
  input  logic          loadDram,
  output ir_pkg::dradrT dradr,
  output logic          dradrValid
);

  import ir_pkg::*;

  logic  instr7xx;
  logic  ioAll;
  dradrT nextAdr;
  logic  lookupQ;

  // I/O class instructions have all three top opcode bits set
  assign instr7xx = (&ir[0:2]) & enIoJrst;

  // IR bits 3..6 all ones selects the I/O device block that shares one dispatch slot
  assign ioAll = &ir[3:6];

  // For 7XX the device code is dropped and the I/O function plus the AC
  // bits pick the dispatch word
  always_comb begin
    if (instr7xx) begin
      nextAdr[0:2] = 3'b111;
      nextAdr[3:5] = ir[7:9] | {3{ioAll}};
      nextAdr[6:8] = ir[10:12];
    end else begin
      nextAdr = ir[0:8];
    end
  end

  // Address register plus a two stage marker
  // The first stage covers the RAM read, the second tells the hold register
  // that the RAM output now belongs to this request
  always_ff @(posedge CON) begin
    if (!rstN) begin
      dradr      <= '0;
      lookupQ    <= 1'b0;
      dradrValid <= 1'b0;
    end else begin
      if (loadDram) begin
        dradr <= nextAdr;
      end
      lookupQ    <= loadDram;
      dradrValid <= lookupQ;
    end
  end

endmodule

/* source/instrRegister.sv */
// IR and dispatch hold register; JRST and the AC gating use the IR value present when the hold loads
`timescale 1ns/10ps
`include "ir_config.svh"

module instrRegister (
  input  logic                                 CON,
  input  logic                                 rstN,
  input  logic                                 loadIr,
  input  logic                                 mbXfer,
  input  logic [0:`IR_AD_WIDTH-1]              ad,
  input  ir_pkg::instrT                        cacheData,
  input  logic [$bits(ir_pkg::dramEntryT)-1:0] ramData,
  input  logic                                 ramValid,
  input  logic                                 enIoJrst,
  input  logic                                 enAc,
  output ir_pkg::instrT                        ir,
  output ir_pkg::acT                           ac,
  output ir_pkg::fieldAbT                      dramA,
  output ir_pkg::fieldAbT                      dramB,
  output ir_pkg::jHighT                        jHigh,
  output ir_pkg::jLowT                         jLow,
  output logic                                 par,
  output logic                                 jrst0,
  output logic                                 acEq0,
  output logic                                 ioLegal,
  output logic                                 dramOddParity
);

  import ir_pkg::*;

  dramEntryT ramWord;
  dramEntryT holdQ;
  logic      jrst;
  logic      jrst0Q;

  assign ramWord = dramEntryT'(ramData);

  // Instruction comes from cache on a memory transfer, else from the adder
  always_ff @(posedge CON) begin
    if (!rstN) begin
      ir <= '0;
    end else if (loadIr) begin
      ir <= mbXfer ? cacheData : ad[0:12];
    end
  end

  // JRST is opcode 254, its AC field selects the flavour of jump
  assign jrst  = enIoJrst && (ir[0:8] == 9'o254);
  assign acEq0 = (ir[9:12] == 4'b0000);

  // Dispatch hold register
  // On a JRST the AC field replaces the low J bits, so each JRST variant
  // gets its own microcode entry, and J bit 4 is cleared to make room
  always_ff @(posedge CON) begin
    if (!rstN) begin
      holdQ  <= '0;
      jrst0Q <= 1'b0;
    end else if (ramValid) begin
      holdQ.a   <= ramWord.a;
      holdQ.b   <= ramWord.b;
      holdQ.par <= ramWord.par;
      if (jrst) begin
        holdQ.jHigh <= {ramWord.jHigh[1:3], 1'b0};
        holdQ.jLow  <= ir[9:12];
      end else begin
        holdQ.jHigh <= ramWord.jHigh;
        holdQ.jLow  <= ramWord.jLow;
      end
      // Plain JRST with AC zero gets its own flag for the CON board
      jrst0Q <= jrst && acEq0;
    end
  end

  assign dramA = holdQ.a;
  assign dramB = holdQ.b;
  assign par   = holdQ.par;
  assign jHigh = holdQ.jHigh;
  assign jLow  = holdQ.jLow;
  assign jrst0 = jrst0Q;

  // AC is forced to zero unless the control register lets it through
  assign ac = enAc ? ir[9:12] : 4'b0000;

  // I/O instructions are legal only with bits 3..6 all set
  assign ioLegal = &ir[3:6];

  // Parity covers the held word as it is presented, so a JRST rewrite shows here
  assign dramOddParity = ^holdQ;

endmodule

/* source/adCondition.sv */
// Combinational AD tests; magic is the CRAM magic bits 7 and 8, dramB must come from the hold register
`timescale 1ns/10ps
`include "ir_config.svh"

module adCondition (
  input  logic [0:`IR_AD_WIDTH-1] ad,
  input  logic                    adCryM2,
  input  logic [7:8]              magic,
  input  ir_pkg::fieldAbT         dramB,
  output logic                    adEq0,
  output logic                    testSatisfied,
  output ir_pkg::normT            norm
);

  logic eqTerm;
  logic gtTerm;
  logic ltTerm;
  logic cryTerm;

  assign adEq0 = ~|ad;

  // B bit 1 asks for AD equal to zero
  assign eqTerm = dramB[1] & adEq0;

  // Greater than uses the true sign, AD bit 0 corrected by the carry out
  assign gtTerm = dramB[2] & magic[7] & (ad[0] ^ adCryM2);

  // Less than only looks at the sign bit
  assign ltTerm = dramB[2] & magic[8] & ad[0];

  // With both magic bits equal the carry alone decides
  assign cryTerm = (magic[7] == magic[8]) & adCryM2;

  // B bit 0 inverts the sense of the whole test
  assign testSatisfied = (eqTerm | gtTerm | ltTerm | cryTerm) ^ dramB[0];

  // Normalize priority encoder
  // Tells the microcode how far the leading one sits from the binary point,
  // the first matching entry wins
  always_comb begin
    if (ad[0]) begin
      norm = 3'd1;
    end else if (|ad[0:6]) begin
      norm = 3'd2;
    end else if (ad[7]) begin
      norm = 3'd3;
    end else if (ad[8]) begin
      norm = 3'd4;
    end else if (ad[9]) begin
      norm = 3'd5;
    end else if (ad[10]) begin
      norm = 3'd6;
    end else if (|ad) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

endmodule

/* source/diagPort.sv */
// Wishbone classic slave with single cycle ack; reads of RAM words return data present before the request edge
`timescale 1ns/10ps
`include "ir_config.svh"

module diagPort (
  input  logic                                 CON,
  input  logic                                 rstN,
  input  logic                                 wbCyc,
  input  logic                                 wbStb,
  input  logic                                 wbWe,
  input  logic [`IR_WB_ADR_WIDTH-1:0]          wbAdr,
  input  logic [`IR_WB_DATA_WIDTH-1:0]         wbDatW,
  input  logic [$bits(ir_pkg::dramEntryT)-1:0] ramRdata,
  input  ir_pkg::dradrT                        dradr,
  input  ir_pkg::normT                         norm,
  input  ir_pkg::acT                           ac,
  input  ir_pkg::fieldAbT                      dramA,
  input  ir_pkg::fieldAbT                      dramB,
  input  ir_pkg::jHighT                        jHigh,
  input  ir_pkg::jLowT                         jLow,
  input  logic                                 par,
  input  logic                                 dramOddParity,
  input  logic                                 testSatisfied,
  input  logic                                 jrst0,
  input  logic                                 adEq0,
  input  logic                                 ioLegal,
  input  logic                                 adCryM2,
  output logic [`IR_WB_DATA_WIDTH-1:0]         wbDatR,
  output logic                                 wbAck,
  output logic                                 ramWe,
  output logic [`IR_DRAM_ADDR_BITS-1:0]        ramAdr,
  output logic [$bits(ir_pkg::dramEntryT)-1:0] ramWdata,
  output logic                                 enIoJrst,
  output logic                                 enAc
);

  localparam int RAM_W = $bits(ir_pkg::dramEntryT);

  logic                         req;
  logic                         isRam;
  logic                         isCtrl;
  logic                         isDiag;
  logic [`IR_WB_ADR_WIDTH-1:0]  diagOff;
  logic [5:0]                   diagVal;
  logic                         ramSelQ;
  logic [`IR_WB_DATA_WIDTH-1:0] datQ;

  // Blocking new requests during the ack cycle keeps ack low in between
  assign req = wbCyc & wbStb & ~wbAck;

  assign diagOff = wbAdr - `IR_DIAG_BASE;
  assign isRam   = (wbAdr < `IR_DRAM_SIZE);
  assign isCtrl  = (wbAdr == `IR_CTRL_ADR);
  assign isDiag  = (diagOff < 8);

  // RAM writes go straight to the RAM port on the request edge
  assign ramWe    = req & wbWe & isRam;
  assign ramAdr   = wbAdr[`IR_DRAM_ADDR_BITS-1:0];
  assign ramWdata = wbDatW[RAM_W-1:0];

  // Diagnostic readout groups, same layout as the EBUS diagnostic functions
  always_comb begin
    case (diagOff[2:0])
      3'd0: diagVal = {norm, dradr[0:2]};
      3'd1: diagVal = dradr[3:8];
      3'd2: diagVal = {enIoJrst, enAc, ac};
      3'd3: diagVal = {dramA, dramB};
      3'd4: diagVal = {testSatisfied, jrst0, jHigh};
      3'd5: diagVal = {par, dramOddParity, jLow};
      3'd6: diagVal = {adEq0, ioLegal, adCryM2, 3'b000};
      default: diagVal = 6'd0;
    endcase
  end

  // Ack and control register
  always_ff @(posedge CON) begin
    if (!rstN) begin
      wbAck    <= 1'b0;
      ramSelQ  <= 1'b0;
      enIoJrst <= 1'b0;
      enAc     <= 1'b0;
    end else begin
      wbAck <= req;
      if (req) begin
        ramSelQ <= isRam;
      end
      if (req && wbWe && isCtrl) begin
        enIoJrst <= wbDatW[0];
        enAc     <= wbDatW[1];
      end
    end
  end

  // Read data for control and diagnostics is captured on the request edge
  // Unmapped words fall through to zero
  always_ff @(posedge CON) begin
    if (req) begin
      if (isCtrl) begin
        datQ <= {{(`IR_WB_DATA_WIDTH - 2){1'b0}}, enAc, enIoJrst};
      end else if (isDiag) begin
        datQ <= {{(`IR_WB_DATA_WIDTH - 6){1'b0}}, diagVal};
      end else begin
        datQ <= '0;
      end
    end
  end

  // The RAM registers its own read on the same edge, so only the select is needed here
  assign wbDatR = ramSelQ ? {{(`IR_WB_DATA_WIDTH - RAM_W){1'b0}}, ramRdata} : datQ;

endmodule

/* source/irTop.sv */
// IR board top; everything runs on CON, dispatch outputs follow loadDram by two cycles
`timescale 1ns/10ps
`include "ir_config.svh"

module irTop (
  input  logic                         CON,
  input  logic                         rstN,
  input  logic                         loadIr,
  input  logic                         mbXfer,
  input  logic [0:`IR_AD_WIDTH-1]      ad,
  input  ir_pkg::instrT                cacheData,
  input  logic                         adCryM2,
  input  logic [7:8]                   magic,
  input  logic                         loadDram,
  input  logic                         wbCyc,
  input  logic                         wbStb,
  input  logic                         wbWe,
  input  logic [`IR_WB_ADR_WIDTH-1:0]  wbAdr,
  input  logic [`IR_WB_DATA_WIDTH-1:0] wbDatW,
  output logic [`IR_WB_DATA_WIDTH-1:0] wbDatR,
  output logic                         wbAck,
  output ir_pkg::instrT                ir,
  output ir_pkg::acT                   ac,
  output ir_pkg::fieldAbT              dramA,
  output ir_pkg::fieldAbT              dramB,
  output ir_pkg::jHighT                jHigh,
  output ir_pkg::jLowT                 jLow,
  output logic                         jrst0,
  output logic                         acEq0,
  output logic                         ioLegal,
  output logic                         adEq0,
  output logic                         testSatisfied,
  output ir_pkg::normT                 norm,
  output logic                         dramOddParity
);

  import ir_pkg::*;

  // Wishbone side of the RAM
  logic                          ramWe;
  logic [`IR_DRAM_ADDR_BITS-1:0] ramAdr;
  logic [$bits(dramEntryT)-1:0]  ramWdata;
  logic [$bits(dramEntryT)-1:0]  ramRdata;

  // Dispatch path
  dradrT                        dradr;
  logic                         dradrValid;
  logic [$bits(dramEntryT)-1:0] dispData;

  logic enIoJrst;
  logic enAc;
  logic par;

  diagPort diag_i (
    .CON, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
    .ramRdata, .dradr, .norm, .ac, .dramA, .dramB, .jHigh, .jLow,
    .par, .dramOddParity, .testSatisfied, .jrst0, .adEq0, .ioLegal, .adCryM2,
    .wbDatR, .wbAck, .ramWe, .ramAdr, .ramWdata, .enIoJrst, .enAc
  );

  dispatchAddress adr_i (
    .CON, .rstN, .ir, .enIoJrst, .loadDram, .dradr, .dradrValid
  );

  dispatchRam dram_i (
    .CON, .rdAdr(dradr), .wbAdr(ramAdr), .wbWe(ramWe), .wbWdata(ramWdata),
    .rdData(dispData), .wbRdata(ramRdata)
  );

  instrRegister ir_i (
    .CON, .rstN, .loadIr, .mbXfer, .ad, .cacheData,
    .ramData(dispData), .ramValid(dradrValid), .enIoJrst, .enAc,
    .ir, .ac, .dramA, .dramB, .jHigh, .jLow, .par, .jrst0, .acEq0, .ioLegal,
    .dramOddParity
  );

  // Tests run on the held B field, so they change with the dispatch outputs
  adCondition adc_i (
    .ad, .adCryM2, .magic, .dramB, .adEq0, .testSatisfied, .norm
  );

endmodule

/* test/ir_assertions.sv */
// Protocol and hold checks bound into irTop; the hold check counts three sampling edges from loadDram
`timescale 1ns/10ps

module irAssertions (
  input logic            CON,
  input logic            rstN,
  input logic            wbCyc,
  input logic            wbStb,
  input logic            wbAck,
  input logic            loadDram,
  input ir_pkg::fieldAbT dramA,
  input ir_pkg::fieldAbT dramB,
  input ir_pkg::jHighT   jHigh,
  input ir_pkg::jLowT    jLow
);

  // Number of assertion failures so far
  int failCount = 0;

  // The master keeps its request up until the slave acks it
  reqHeld: assert property (@(posedge CON) disable iff (!rstN)
    (wbCyc && wbStb && !wbAck) |=> (wbCyc && wbStb))
    else begin
      failCount++;
      $error("request dropped before wbAck");
    end

  // An ack only ever lands inside an open bus cycle
  ackInCycle: assert property (@(posedge CON) disable iff (!rstN)
    wbAck |-> wbCyc)
    else begin
      failCount++;
      $error("wbAck outside a bus cycle");
    end

  // The hold register only moves when a lookup was sampled three sample points back
  holdStable: assert property (@(posedge CON) disable iff (!rstN)
    !$past(loadDram, 3) |-> $stable({dramA, dramB, jHigh, jLow}))
    else begin
      failCount++;
      $error("dispatch outputs changed without a lookup");
    end

endmodule

bind irTop irAssertions checks_i (
  .CON(CON), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
  .loadDram(loadDram), .dramA(dramA), .dramB(dramB), .jHigh(jHigh), .jLow(jLow)
);

/* test/irTb.sv */
// Directed testbench for irTop; it assumes a 2 cycle dispatch latency and stops at the first mismatch
`timescale 1ns/10ps
`include "ir_config.svh"

module irTb;

  // About four times the roughly 1200 cycles that all tests take together
  localparam int TIMEOUT_CYCLES = 5000;

  logic                         CON;
  logic                         rstN;
  logic                         loadIr;
  logic                         mbXfer;
  logic [0:`IR_AD_WIDTH-1]      ad;
  logic [0:12]                  cacheData;
  logic                         adCryM2;
  logic [7:8]                   magic;
  logic                         loadDram;
  logic                         wbCyc;
  logic                         wbStb;
  logic                         wbWe;
  logic [`IR_WB_ADR_WIDTH-1:0]  wbAdr;
  logic [`IR_WB_DATA_WIDTH-1:0] wbDatW;
  logic [`IR_WB_DATA_WIDTH-1:0] wbDatR;
  logic                         wbAck;
  logic [0:12]                  ir;
  logic [9:12]                  ac;
  logic [0:2]                   dramA;
  logic [0:2]                   dramB;
  logic [1:4]                   jHigh;
  logic [7:10]                  jLow;
  logic                         jrst0;
  logic                         acEq0;
  logic                         ioLegal;
  logic                         adEq0;
  logic                         testSatisfied;
  logic [0:2]                   norm;
  logic                         dramOddParity;

  // Words written over Wishbone and the control register as the bench last set it
  logic [14:0] ramModel [0:511];
  logic [1:0]  ctrlModel;
  int          cycleCount = 0;

  irTop dut_i (.*);

  initial begin
    CON = 1'b0;
    forever #50 CON = ~CON;
  end

  // Watchdog that runs on the clock independent of the test flow
  always @(posedge CON) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic checkValue(input string name, input logic [35:0] expected,
                            input logic [35:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // One Wishbone classic cycle that is held until the slave acks
  task automatic busTransfer(input logic we, input logic [9:0] adr, input logic [15:0] wdata,
                             output logic [15:0] rdata);
    @(posedge CON);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= we;
    wbAdr  <= adr;
    wbDatW <= wdata;
    @(negedge CON);
    while (!wbAck) @(negedge CON);
    rdata = wbDatR;
    @(posedge CON);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic wbWrite(input logic [9:0] adr, input logic [15:0] data);
    logic [15:0] unused;
    busTransfer(1'b1, adr, data, unused);
  endtask

  task automatic wbRead(input logic [9:0] adr, output logic [15:0] data);
    busTransfer(1'b0, adr, 16'd0, data);
  endtask

  // Bit 0 is enIoJrst and bit 1 is enAc
  task automatic setCtrl(input logic [1:0] v);
    wbWrite(`IR_CTRL_ADR, {14'd0, v});
    ctrlModel = v;
  endtask

  // The unused source gets the inverted value, so a wrong select shows up
  task automatic loadInstr(input logic [0:12] instr, input logic viaCache);
    @(posedge CON);
    loadIr    <= 1'b1;
    mbXfer    <= viaCache;
    cacheData <= viaCache ? instr : ~instr;
    ad[0:12]  <= viaCache ? ~instr : instr;
    @(posedge CON);
    loadIr <= 1'b0;
    mbXfer <= 1'b0;
    @(negedge CON);
    checkValue("ir load", 36'(instr), 36'(ir));
  endtask

  // Dispatch outputs settle 2 edges after the edge that samples loadDram
  task automatic lookup();
    @(posedge CON);
    loadDram <= 1'b1;
    @(posedge CON);
    loadDram <= 1'b0;
    repeat (2) @(posedge CON);
    @(negedge CON);
  endtask

  function automatic logic [0:8] expectAdr(input logic [0:12] instr, input logic enIo);
    logic [0:8] a;
    a = instr[0:8];
    if (enIo && instr[0:2] == 3'o7) begin
      a[3:5] = instr[7:9];
      if (instr[3:6] == 4'hF) a[3:5] = 3'o7;
      a[6:8] = instr[10:12];
    end
    return a;
  endfunction

  function automatic logic expectTest(input logic [0:35] a, input logic cry,
                                      input logic [7:8] m, input logic [0:2] b);
    logic t;
    t = 1'b0;
    if (b[1] && a == '0) t = 1'b1;
    if (b[2] && m[7] && (a[0] != cry)) t = 1'b1;
    if (b[2] && m[8] && a[0]) t = 1'b1;
    if ((m[7] == m[8]) && cry) t = 1'b1;
    return b[0] ? !t : t;
  endfunction

  // Scanning from the end leaves the first matching position in code
  function automatic logic [0:2] expectNorm(input logic [0:35] a);
    logic [1:7] hit;
    logic [0:2] code;
    hit  = {a[0], |a[0:6], a[7], a[8], a[9], a[10], |a};
    code = 3'd0;
    for (int i = 7; i >= 1; i--) begin
      if (hit[i]) code = 3'(i);
    end
    return code;
  endfunction

  // Writes entry where instr will dispatch, runs the lookup and checks every IR output
  task automatic dispatchCase(input string name, input logic [0:12] instr,
                              input logic [14:0] entry, input logic viaCache);
    logic [0:8]  adr;
    logic [15:0] rd;
    logic [0:2]  expA;
    logic [0:2]  expB;
    logic        expPar;
    logic [1:4]  expJh;
    logic [7:10] expJl;
    logic        isJrst;
    adr = expectAdr(instr, ctrlModel[0]);
    wbWrite(10'(adr), {1'b0, entry});
    ramModel[adr] = entry;
    loadInstr(instr, viaCache);
    lookup();
    {expA, expB, expPar, expJh, expJl} = entry;
    isJrst = ctrlModel[0] && instr[0:8] == 9'o254;
    // JRST puts the AC field into J and clears J bit 4
    if (isJrst) begin
      expJh[4] = 1'b0;
      expJl    = instr[9:12];
    end
    checkValue({name, " dramA"}, 36'(expA), 36'(dramA));
    checkValue({name, " dramB"}, 36'(expB), 36'(dramB));
    checkValue({name, " jHigh"}, 36'(expJh), 36'(jHigh));
    checkValue({name, " jLow"}, 36'(expJl), 36'(jLow));
    checkValue({name, " jrst0"}, 36'(isJrst && instr[9:12] == 4'd0), 36'(jrst0));
    checkValue({name, " acEq0"}, 36'(instr[9:12] == 4'd0), 36'(acEq0));
    checkValue({name, " ioLegal"}, 36'(&instr[3:6]), 36'(ioLegal));
    checkValue({name, " ac"}, 36'(ctrlModel[1] ? instr[9:12] : 4'd0), 36'(ac));
    checkValue({name, " parity"}, 36'(^{expA, expB, expPar, expJh, expJl}),
               36'(dramOddParity));
    wbRead(`IR_DIAG_BASE, rd);
    checkValue({name, " group0 address"}, 36'(adr[0:2]), 36'(rd[2:0]));
    wbRead(`IR_DIAG_BASE + 10'd1, rd);
    checkValue({name, " group1 address"}, 36'(adr[3:8]), 36'(rd[5:0]));
    wbRead(`IR_DIAG_BASE + 10'd5, rd);
    checkValue({name, " group5"}, 36'({expPar, ^{expA, expB, expPar, expJh, expJl}, expJl}),
               36'(rd));
  endtask

  task automatic adCase(input logic [0:35] adv, input logic cry, input logic [7:8] m,
                        input logic [0:2] b);
    @(posedge CON);
    ad      <= adv;
    adCryM2 <= cry;
    magic   <= m;
    @(negedge CON);
    checkValue("ad conditions adEq0", 36'(adv == '0), 36'(adEq0));
    checkValue("ad conditions testSatisfied", 36'(expectTest(adv, cry, m, b)),
               36'(testSatisfied));
    checkValue("ad conditions norm", 36'(expectNorm(adv)), 36'(norm));
  endtask

  task automatic testDramAccess();
    logic [9:0]  adrs [16];
    logic [15:0] rd;
    for (int i = 0; i < 16; i++) begin
      adrs[i] = {1'b0, 9'($urandom)};
      ramModel[adrs[i][8:0]] = 15'($urandom);
      wbWrite(adrs[i], {1'b0, ramModel[adrs[i][8:0]]});
    end
    // Repeated addresses compare against the last write
    for (int i = 0; i < 16; i++) begin
      wbRead(adrs[i], rd);
      checkValue("dram access", 36'({1'b0, ramModel[adrs[i][8:0]]}), 36'(rd));
    end
    setCtrl(2'b11);
    wbRead(`IR_CTRL_ADR, rd);
    checkValue("dram access control", 36'd3, 36'(rd));
    setCtrl(2'b01);
    wbRead(`IR_CTRL_ADR, rd);
    checkValue("dram access control", 36'd1, 36'(rd));
    wbWrite(10'h3FF, 16'hFFFF);
    wbRead(10'h3FF, rd);
    checkValue("dram access unmapped", 36'd0, 36'(rd));
    wbRead(10'h201, rd);
    checkValue("dram access unmapped", 36'd0, 36'(rd));
  endtask

  task automatic testNormalDispatch();
    logic [0:12] instr;
    for (int i = 0; i < 8; i++) begin
      setCtrl({i[0], 1'b1});
      do begin
        instr = 13'($urandom);
      end while (instr[0:2] == 3'o7 || instr[0:8] == 9'o254);
      dispatchCase("normal dispatch", instr, 15'($urandom), i[1]);
    end
  endtask

  task automatic testIoRemap();
    logic [0:12] instr;
    for (int i = 0; i < 8; i++) begin
      setCtrl({1'b0, ~i[0]});
      instr = {3'o7, 10'($urandom)};
      // The second half covers the shared slot with bits 3..6 all ones
      if (i >= 4) begin
        instr[3:6] = 4'hF;
      end else if (instr[3:6] == 4'hF) begin
        instr[3] = 1'b0;
      end
      dispatchCase("7xx remap", instr, 15'($urandom), 1'b0);
    end
  endtask

  task automatic testJrst();
    for (int i = 0; i < 6; i++) begin
      setCtrl({1'b1, i < 4});
      dispatchCase("jrst", {9'o254, 4'(i * 5)}, 15'($urandom), i[0]);
    end
  endtask

  task automatic testAdConditions();
    logic [14:0] entry;
    logic [0:35] adv;
    logic [15:0] rd;
    int          bitPos [9] = '{-1, 0, 3, 6, 7, 8, 9, 10, 30};
    setCtrl(2'b00);
    for (int b = 0; b < 8; b++) begin
      entry = 15'($urandom);
      entry[11:9] = 3'(b);
      dispatchCase("ad conditions B load", {9'(b + 8), 4'd0}, entry, 1'b0);
      for (int k = 0; k < 13; k++) begin
        adv = '0;
        if (k < 9) begin
          if (bitPos[k] >= 0) adv[bitPos[k]] = 1'b1;
        end else begin
          adv = {4'($urandom), $urandom()} >> ($urandom() % 36);
        end
        adCase(adv, 1'($urandom), 2'($urandom), 3'(b));
      end
    end
    // The last IR was opcode 017, so bits 3..6 are not all ones
    adCase('0, 1'b1, 2'b10, 3'd7);
    wbRead(`IR_DIAG_BASE + 10'd6, rd);
    checkValue("ad conditions group6", 36'({1'b1, 1'b0, 1'b1, 3'b000}), 36'(rd));
  endtask

  task automatic testParity();
    logic [14:0] pats [5] = '{15'h0000, 15'h7FFF, 15'h0001, 15'h5555, 15'h2A6C};
    setCtrl(2'b01);
    for (int i = 0; i < 5; i++) begin
      dispatchCase("parity", {9'o123, 4'(i)}, pats[i], 1'b1);
    end
    // A JRST rewrite changes the held bits that parity covers
    dispatchCase("parity jrst", {9'o254, 4'd6}, 15'h7FFF, 1'b0);
  endtask

  initial begin
    void'($urandom(72));
    rstN      = 1'b0;
    loadIr    = 1'b0;
    mbXfer    = 1'b0;
    ad        = '0;
    cacheData = '0;
    adCryM2   = 1'b0;
    magic     = 2'b00;
    loadDram  = 1'b0;
    wbCyc     = 1'b0;
    wbStb     = 1'b0;
    wbWe      = 1'b0;
    wbAdr     = '0;
    wbDatW    = '0;
    ctrlModel = 2'b00;
    repeat (5) @(posedge CON);
    rstN <= 1'b1;
    testDramAccess();
    testNormalDispatch();
    testIoRemap();
    testJrst();
    testAdConditions();
    testParity();
    if (dut_i.checks_i.failCount != 0) begin
      $display("Bound assertions failed %0d times", dut_i.checks_i.failCount);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* sim.f */
+incdir+source
source/ir_pkg.sv
source/dispatchRam.sv
source/dispatchAddress.sv
source/instrRegister.sv
source/adCondition.sv
source/diagPort.sv
source/irTop.sv
test/ir_assertions.sv
test/irTb.sv

/* Makefile */
# Verilator build and run for the IR board testbench

VERILATOR ?= verilator
TOP       ?= irTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?=

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The binary exits nonzero on $fatal, so make reports the failure
run: compile
	./$(BINARY) $(RUNFLAGS)

clean:
	rm -rf $(OBJ_DIR)
